// File: common/axis_pkt_pkg.sv
// Packet trailer package with stream beat types, widths and trailer layout

package axis_pkt_pkg;

   // --------------------------------------------------
   // Stream widths
   // --------------------------------------------------
   localparam int DATA_W = 64;
   localparam int KEEP_W = DATA_W / 8;
   localparam int LEN_W  = 16;
   localparam int CSUM_W = 16;

   typedef logic [DATA_W-1:0] axis_data_t;
   typedef logic [KEEP_W-1:0] axis_keep_t;
   // Packet byte count, wraps above 65535
   typedef logic [LEN_W-1:0]  pkt_len_t;
   // Sum of all packet bytes modulo 2^16
   typedef logic [CSUM_W-1:0] csum_t;

   // One stream beat, 73 bits
   typedef struct packed {
      axis_data_t data;
      axis_keep_t keep;
      logic       last;
   } axis_beat_t;

   // Beat plus running totals, totals meaningful on last beat only
   typedef struct packed {
      axis_beat_t beat;
      pkt_len_t   len;
      csum_t      csum;
   } acc_beat_t;

   // --------------------------------------------------
   // Trailer layout
   // --------------------------------------------------
   // Bytes 0-1 byte count, bytes 2-3 checksum, both low byte first
   localparam int         TRL_LEN_LSB  = 0;
   localparam int         TRL_CSUM_LSB = 16;
   localparam axis_keep_t TRAILER_KEEP = 8'h0f;

   // Builds the trailer beat from the packet totals
   function automatic axis_beat_t trailer_beat(pkt_len_t len, csum_t csum);
      axis_beat_t b;
      b.data = '0;
      b.data[TRL_LEN_LSB +: LEN_W]   = len;
      b.data[TRL_CSUM_LSB +: CSUM_W] = csum;
      b.keep = TRAILER_KEEP;
      b.last = 1'b1;
      return b;
   endfunction

endpackage

// File: verilog/axis_reg_slice.sv
// Stream register slice, main plus skid register with registered ready
`timescale 1ns/1ns

module axis_reg_slice (
   input  logic                     axis_clk,
   input  logic                     axis_rst_n,
   // Upstream side
   input  axis_pkt_pkg::axis_beat_t in_beat_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   // Downstream side
   output axis_pkt_pkg::axis_beat_t out_beat_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i
);

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------
   axis_pkt_pkg::axis_beat_t main_beat_q;
   axis_pkt_pkg::axis_beat_t skid_beat_q;
   logic                     main_valid_q;
   logic                     skid_valid_q;
   // Main register is free or being emptied this cycle
   logic                     main_load;
   logic                     in_fire;

   // Ready comes straight from a flop, cuts the downstream ready path
   assign in_ready_o = ~skid_valid_q;
   assign in_fire    = in_valid_i & in_ready_o;
   assign main_load  = ~main_valid_q | out_ready_i;

   // --------------------------------------------------
   // Valid flags
   // --------------------------------------------------
   always_ff @(posedge axis_clk or negedge axis_rst_n) begin
      if (!axis_rst_n) begin
         main_valid_q <= 1'b0;
         skid_valid_q <= 1'b0;
      end else if (main_load) begin
         // Skid beat drains first, input is held off meanwhile
         main_valid_q <= skid_valid_q | in_valid_i;
         skid_valid_q <= 1'b0;
      end else if (in_fire) begin
         // Main stalled, park the new beat in the skid
         skid_valid_q <= 1'b1;
      end
   end

   // --------------------------------------------------
   // Payload
   // --------------------------------------------------
   always_ff @(posedge axis_clk) begin
      if (main_load) begin
         main_beat_q <= skid_valid_q ? skid_beat_q : in_beat_i;
      end
      if (in_fire) begin
         skid_beat_q <= in_beat_i;
      end
   end

   assign out_beat_o  = main_beat_q;
   assign out_valid_o = main_valid_q;

endmodule

// File: trailer/pkt_accum.sv
// Packet accumulator, forwards beats and sums byte count and checksum
`timescale 1ns/1ns

module pkt_accum (
   input  logic                     axis_clk,
   input  logic                     axis_rst_n,
   // Upstream side
   input  axis_pkt_pkg::axis_beat_t in_beat_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   // Downstream side, beat with totals
   output axis_pkt_pkg::acc_beat_t  out_beat_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i
);

   // --------------------------------------------------
   // Per-beat byte count and byte sum
   // --------------------------------------------------
   axis_pkt_pkg::pkt_len_t  beat_len;
   axis_pkt_pkg::csum_t     beat_sum;
   // Running totals of the packet so far
   axis_pkt_pkg::pkt_len_t  len_q;
   axis_pkt_pkg::csum_t     csum_q;
   axis_pkt_pkg::acc_beat_t src_beat;

   always_comb begin
      beat_len = '0;
      beat_sum = '0;
      // Only kept bytes count toward the totals
      for (int i = 0; i < axis_pkt_pkg::KEEP_W; i++) begin
         if (in_beat_i.keep[i]) begin
            beat_len = beat_len + axis_pkt_pkg::pkt_len_t'(1);
            beat_sum = beat_sum + axis_pkt_pkg::csum_t'(in_beat_i.data[i*8 +: 8]);
         end
      end
   end

   // Totals include the current beat
   assign src_beat.beat = in_beat_i;
   assign src_beat.len  = len_q + beat_len;
   assign src_beat.csum = csum_q + beat_sum;

   // --------------------------------------------------
   // Output register with skid entry
   // --------------------------------------------------
   axis_pkt_pkg::acc_beat_t main_beat_q;
   axis_pkt_pkg::acc_beat_t skid_beat_q;
   logic                    main_valid_q;
   logic                    skid_valid_q;
   logic                    main_load;
   logic                    in_fire;

   assign in_ready_o = ~skid_valid_q;
   assign in_fire    = in_valid_i & in_ready_o;
   assign main_load  = ~main_valid_q | out_ready_i;

   always_ff @(posedge axis_clk or negedge axis_rst_n) begin
      if (!axis_rst_n) begin
         main_valid_q <= 1'b0;
         skid_valid_q <= 1'b0;
         len_q        <= '0;
         csum_q       <= '0;
      end else begin
         if (main_load) begin
            main_valid_q <= skid_valid_q | in_valid_i;
            skid_valid_q <= 1'b0;
         end else if (in_fire) begin
            skid_valid_q <= 1'b1;
         end
         // Totals restart at zero once the last beat is taken
         if (in_fire) begin
            len_q  <= in_beat_i.last ? '0 : src_beat.len;
            csum_q <= in_beat_i.last ? '0 : src_beat.csum;
         end
      end
   end

   always_ff @(posedge axis_clk) begin
      if (main_load) begin
         main_beat_q <= skid_valid_q ? skid_beat_q : src_beat;
      end
      if (in_fire) begin
         skid_beat_q <= src_beat;
      end
   end

   assign out_beat_o  = main_beat_q;
   assign out_valid_o = main_valid_q;

endmodule

// File: trailer/trailer_insert.sv
// Trailer inserter, forwards packet data then appends the totals beat
`timescale 1ns/1ns

module trailer_insert (
   input  logic                     axis_clk,
   input  logic                     axis_rst_n,
   // Upstream side, beat with totals
   input  axis_pkt_pkg::acc_beat_t  in_beat_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   // Downstream side
   output axis_pkt_pkg::axis_beat_t out_beat_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i
);

   typedef enum logic {
      FORWARD,
      TRAILER
   } state_t;

   state_t                   state_q;
   // Totals latched from the last data beat
   axis_pkt_pkg::pkt_len_t   trl_len_q;
   axis_pkt_pkg::csum_t      trl_csum_q;

   // --------------------------------------------------
   // Source select, input data or generated trailer
   // --------------------------------------------------
   axis_pkt_pkg::axis_beat_t src_beat;
   logic                     src_valid;
   logic                     src_fire;
   logic                     slice_ready;
   logic                     in_fire;

   always_comb begin
      if (state_q == TRAILER) begin
         src_beat  = axis_pkt_pkg::trailer_beat(trl_len_q, trl_csum_q);
         src_valid = 1'b1;
      end else begin
         // Data beats never end the outgoing packet
         src_beat      = in_beat_i.beat;
         src_beat.last = 1'b0;
         src_valid     = in_valid_i;
      end
   end

   // Input is held off while the trailer is pending
   assign in_ready_o = (state_q == FORWARD) & slice_ready;
   assign in_fire    = in_valid_i & in_ready_o;
   assign src_fire   = src_valid & slice_ready;

   // --------------------------------------------------
   // State machine
   // --------------------------------------------------
   always_ff @(posedge axis_clk or negedge axis_rst_n) begin
      if (!axis_rst_n) begin
         state_q <= FORWARD;
      end else if (state_q == FORWARD) begin
         if (in_fire && in_beat_i.beat.last) begin
            state_q <= TRAILER;
         end
      end else if (src_fire) begin
         // Trailer taken into the output slice
         state_q <= FORWARD;
      end
   end

   always_ff @(posedge axis_clk) begin
      if (in_fire && in_beat_i.beat.last) begin
         trl_len_q  <= in_beat_i.len;
         trl_csum_q <= in_beat_i.csum;
      end
   end

   // --------------------------------------------------
   // Output register with skid entry
   // --------------------------------------------------
   axis_pkt_pkg::axis_beat_t main_beat_q;
   axis_pkt_pkg::axis_beat_t skid_beat_q;
   logic                     main_valid_q;
   logic                     skid_valid_q;
   logic                     main_load;

   assign slice_ready = ~skid_valid_q;
   assign main_load   = ~main_valid_q | out_ready_i;

   always_ff @(posedge axis_clk or negedge axis_rst_n) begin
      if (!axis_rst_n) begin
         main_valid_q <= 1'b0;
         skid_valid_q <= 1'b0;
      end else if (main_load) begin
         main_valid_q <= skid_valid_q | src_valid;
         skid_valid_q <= 1'b0;
      end else if (src_fire) begin
         skid_valid_q <= 1'b1;
      end
   end

   always_ff @(posedge axis_clk) begin
      if (main_load) begin
         main_beat_q <= skid_valid_q ? skid_beat_q : src_beat;
      end
      if (src_fire) begin
         skid_beat_q <= src_beat;
      end
   end

   assign out_beat_o  = main_beat_q;
   assign out_valid_o = main_valid_q;

endmodule

// File: verilog/axis_pkt_trailer_top.sv
// Packet trailer top, register slice then accumulator then trailer insert
`timescale 1ns/1ns

module axis_pkt_trailer_top (
   input  logic                     axis_clk,
   input  logic                     axis_rst_n,
   // Input stream
   input  axis_pkt_pkg::axis_beat_t s_beat_i,
   input  logic                     s_valid_i,
   output logic                     s_ready_o,
   // Output stream with trailer beats
   output axis_pkt_pkg::axis_beat_t m_beat_o,
   output logic                     m_valid_o,
   input  logic                     m_ready_i
);

   // --------------------------------------------------
   // Stage links
   // --------------------------------------------------
   // Slice to accumulator
   axis_pkt_pkg::axis_beat_t rs_beat;
   logic                     rs_valid;
   logic                     rs_ready;
   // Accumulator to trailer insert
   axis_pkt_pkg::acc_beat_t  acc_beat;
   logic                     acc_valid;
   logic                     acc_ready;

   axis_reg_slice u_reg_slice (
      .axis_clk    (axis_clk),
      .axis_rst_n  (axis_rst_n),
      .in_beat_i   (s_beat_i),
      .in_valid_i  (s_valid_i),
      .in_ready_o  (s_ready_o),
      .out_beat_o  (rs_beat),
      .out_valid_o (rs_valid),
      .out_ready_i (rs_ready)
   );

   pkt_accum u_pkt_accum (
      .axis_clk    (axis_clk),
      .axis_rst_n  (axis_rst_n),
      .in_beat_i   (rs_beat),
      .in_valid_i  (rs_valid),
      .in_ready_o  (rs_ready),
      .out_beat_o  (acc_beat),
      .out_valid_o (acc_valid),
      .out_ready_i (acc_ready)
   );

   trailer_insert u_trailer_insert (
      .axis_clk    (axis_clk),
      .axis_rst_n  (axis_rst_n),
      .in_beat_i   (acc_beat),
      .in_valid_i  (acc_valid),
      .in_ready_o  (acc_ready),
      .out_beat_o  (m_beat_o),
      .out_valid_o (m_valid_o),
      .out_ready_i (m_ready_i)
   );

endmodule

// File: verification/axis_pkt_checker.sv
// Output stream monitor that rebuilds each packet and its trailer and compares every beat
`timescale 1ns/1ns

module axis_pkt_checker (
   input logic                     axis_clk,
   input logic                     axis_rst_n,
   input axis_pkt_pkg::axis_beat_t beat_i,
   input logic                     valid_i,
   input logic                     ready_i,
   input logic                     in_ready_i
);

   // --------------------------------------------------
   // Expected packets as filled by the driver
   // --------------------------------------------------
   logic [7:0]  exp_bytes[$];
   string       exp_names[$];
   int          exp_lens[$];
   logic        exp_fixed[$];
   logic [15:0] exp_csums[$];

   // Packet being received
   string       cur_name;
   int          cur_len;
   int          cur_rem;
   int          cur_beat;
   logic [15:0] cur_sum;
   logic        cur_fixed;
   logic [15:0] cur_csum_tab;
   logic        cur_bad;
   logic        in_pkt = 1'b0;

   int pkt_done   = 0;
   int pkt_failed = 0;
   int err_cnt    = 0;

   task automatic push_byte(input logic [7:0] b);
      exp_bytes.push_back(b);
   endtask

   // Fixed checksum comes straight from the table for constant-fill rows
   task automatic push_packet(input string name, input int len, input logic fixed,
                              input logic [15:0] csum);
      exp_names.push_back(name);
      exp_lens.push_back(len);
      exp_fixed.push_back(fixed);
      exp_csums.push_back(csum);
   endtask

   // Compares one output beat against its expected value
   task automatic compare_beat(input axis_pkt_pkg::axis_beat_t exp);
      if (beat_i !== exp) begin
         err_cnt++;
         if (!cur_bad) begin
            $display("FAILED %s beat %0d expected %h actual %h",
                     cur_name, cur_beat, exp, beat_i);
         end
         cur_bad = 1'b1;
      end
      cur_beat++;
   endtask

   // --------------------------------------------------
   // Per-beat model
   // --------------------------------------------------
   task automatic take_beat();
      axis_pkt_pkg::axis_beat_t exp;
      int                       n;
      if (!in_pkt) begin
         if (exp_names.size() == 0) begin
            err_cnt++;
            $display("Output beat arrived with no packet outstanding: %h", beat_i);
            return;
         end
         cur_name     = exp_names.pop_front();
         cur_len      = exp_lens.pop_front();
         cur_fixed    = exp_fixed.pop_front();
         cur_csum_tab = exp_csums.pop_front();
         cur_rem      = cur_len;
         cur_beat     = 0;
         cur_sum      = '0;
         cur_bad      = 1'b0;
         in_pkt       = 1'b1;
      end
      exp = '0;
      if (cur_rem > 0) begin
         // Data beat packed low byte first with keep filled from bit 0
         n = (cur_rem > 8) ? 8 : cur_rem;
         for (int i = 0; i < n; i++) begin
            exp.data[i*8 +: 8] = exp_bytes.pop_front();
            exp.keep[i]        = 1'b1;
            cur_sum            = cur_sum + 16'(exp.data[i*8 +: 8]);
         end
         cur_rem -= n;
         compare_beat(exp);
      end else begin
         // Trailer with count in bytes 0-1 and sum in bytes 2-3
         exp.data[15:0]  = 16'(cur_len);
         exp.data[31:16] = cur_fixed ? cur_csum_tab : cur_sum;
         exp.keep        = axis_pkt_pkg::TRAILER_KEEP;
         exp.last        = 1'b1;
         compare_beat(exp);
         pkt_done++;
         if (cur_bad) begin
            pkt_failed++;
         end else begin
            $display("PASSED %s len %0d csum %h", cur_name, cur_len, exp.data[31:16]);
         end
         in_pkt = 1'b0;
      end
   endtask

   always @(posedge axis_clk) begin
      if (axis_rst_n && valid_i && ready_i) begin
         take_beat();
      end
   end

   // Input side accepts beats from the first cycle out of reset
   initial begin
      @(posedge axis_rst_n);
      @(posedge axis_clk);
      if (in_ready_i !== 1'b1) begin
         err_cnt++;
         $display("Input ready was not high on the first cycle after reset");
      end
   end

endmodule

// File: verification/axis_pkt_trailer_props.sv
// Output stream assertions, handshake hold and trailer beat form
`timescale 1ns/1ns

module axis_pkt_trailer_props (
   input logic                     axis_clk,
   input logic                     axis_rst_n,
   input axis_pkt_pkg::axis_beat_t beat_i,
   input logic                     valid_i,
   input logic                     ready_i
);

   // Number of failed assertion checks
   int unsigned fail_cnt = 0;

   // --------------------------------------------------
   // Handshake
   // --------------------------------------------------
   valid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
      valid_i && !ready_i |=> valid_i)
      else begin
         $error("Output valid dropped before the beat was taken");
         fail_cnt++;
      end

   // Stalled beat keeps its payload
   beat_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
      valid_i && !ready_i |=> $stable(beat_i))
      else begin
         $error("Output beat changed while stalled");
         fail_cnt++;
      end

   // --------------------------------------------------
   // Trailer form
   // --------------------------------------------------
   trailer_form: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
      valid_i && beat_i.last |->
         beat_i.keep == axis_pkt_pkg::TRAILER_KEEP
         && beat_i.data[axis_pkt_pkg::DATA_W-1:32] == '0)
      else begin
         $error("Last beat is not a well-formed trailer");
         fail_cnt++;
      end

endmodule

bind axis_pkt_trailer_top axis_pkt_trailer_props u_props (
   .axis_clk   (axis_clk),
   .axis_rst_n (axis_rst_n),
   .beat_i     (m_beat_o),
   .valid_i    (m_valid_o),
   .ready_i    (m_ready_i)
);

// File: verification/axis_pkt_trailer_tb.sv
// Packet trailer testbench that drives the packet table with optional random back-pressure
`timescale 1ns/1ns

module axis_pkt_trailer_tb;

   localparam int          N_TESTS    = 14;
   localparam int          RST_CYCLES = 5;
   localparam logic [31:0] SEED       = 32'h37c0_3ac8;

   // One row per test
   // Checksum field is used only for constant-fill rows
   typedef struct {
      string       name;
      int          len;
      logic        stall;
      int          gap;
      logic        reuse;
      logic        fill_ff;
      logic [15:0] exp_csum;
   } test_row_t;

   test_row_t                tbl [N_TESTS];
   logic                     axis_clk;
   logic                     axis_rst_n;
   axis_pkt_pkg::axis_beat_t s_beat_i;
   logic                     s_valid_i;
   logic                     s_ready_o;
   axis_pkt_pkg::axis_beat_t m_beat_o;
   logic                     m_valid_o;
   logic                     m_ready_i;
   // Separate LCG streams for packet bytes and ready
   logic [31:0]              byte_state;
   logic [31:0]              rdy_state;
   logic [7:0]               pkt_bytes[$];

   axis_pkt_trailer_top UUT (
      .axis_clk   (axis_clk),
      .axis_rst_n (axis_rst_n),
      .s_beat_i   (s_beat_i),
      .s_valid_i  (s_valid_i),
      .s_ready_o  (s_ready_o),
      .m_beat_o   (m_beat_o),
      .m_valid_o  (m_valid_o),
      .m_ready_i  (m_ready_i)
   );

   axis_pkt_checker u_checker (
      .axis_clk   (axis_clk),
      .axis_rst_n (axis_rst_n),
      .beat_i     (m_beat_o),
      .valid_i    (m_valid_o),
      .ready_i    (m_ready_i),
      .in_ready_i (s_ready_o)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // --------------------------------------------------
   // Test table
   // --------------------------------------------------
   task automatic load_table();
      tbl[0]  = '{"single_8",       8,   1'b0, 0, 1'b0, 1'b0, 16'h0000};
      tbl[1]  = '{"len_1",          1,   1'b0, 2, 1'b0, 1'b0, 16'h0000};
      tbl[2]  = '{"len_7",          7,   1'b0, 2, 1'b0, 1'b0, 16'h0000};
      tbl[3]  = '{"len_9",          9,   1'b0, 2, 1'b0, 1'b0, 16'h0000};
      tbl[4]  = '{"len_16",         16,  1'b0, 2, 1'b0, 1'b0, 16'h0000};
      tbl[5]  = '{"len_61",         61,  1'b0, 2, 1'b0, 1'b0, 16'h0000};
      // Same bytes as len_61 under output stalls
      tbl[6]  = '{"stall_61",       61,  1'b1, 2, 1'b1, 1'b0, 16'h0000};
      tbl[7]  = '{"b2b_24",         24,  1'b0, 0, 1'b0, 1'b0, 16'h0000};
      tbl[8]  = '{"b2b_13",         13,  1'b0, 0, 1'b0, 1'b0, 16'h0000};
      tbl[9]  = '{"b2b_5",          5,   1'b0, 0, 1'b0, 1'b0, 16'h0000};
      tbl[10] = '{"stall_b2b_40",   40,  1'b1, 0, 1'b0, 1'b0, 16'h0000};
      tbl[11] = '{"stall_b2b_3",    3,   1'b1, 0, 1'b0, 1'b0, 16'h0000};
      // 600 * 0xff is 153000 which is 0x55a8 modulo 2^16
      tbl[12] = '{"wrap_600",       600, 1'b0, 2, 1'b0, 1'b1, 16'h55a8};
      tbl[13] = '{"wrap_600_stall", 600, 1'b1, 0, 1'b0, 1'b1, 16'h55a8};
   endtask

   // Output beats of the whole table plus idle gaps
   function automatic int table_beats();
      int sum;
      sum = 0;
      for (int r = 0; r < N_TESTS; r++) begin
         sum += (tbl[r].len + 7) / 8 + 1 + tbl[r].gap;
      end
      return sum;
   endfunction

   // --------------------------------------------------
   // Stimulus driver
   // --------------------------------------------------
   task automatic send_packet(input int r);
      axis_pkt_pkg::axis_beat_t beat;
      int                       idx;
      int                       n;
      if (!tbl[r].reuse) begin
         pkt_bytes.delete();
         for (int i = 0; i < tbl[r].len; i++) begin
            byte_state = lcg_next(byte_state);
            pkt_bytes.push_back(tbl[r].fill_ff ? 8'hff : byte_state[23:16]);
         end
      end
      foreach (pkt_bytes[i]) begin
         u_checker.push_byte(pkt_bytes[i]);
      end
      u_checker.push_packet(tbl[r].name, tbl[r].len, tbl[r].fill_ff, tbl[r].exp_csum);
      s_valid_i = 1'b0;
      repeat (tbl[r].gap) begin
         @(posedge axis_clk);
         #1;
      end
      idx = 0;
      while (idx < tbl[r].len) begin
         n    = (tbl[r].len - idx > 8) ? 8 : tbl[r].len - idx;
         beat = '0;
         for (int i = 0; i < n; i++) begin
            beat.data[i*8 +: 8] = pkt_bytes[idx+i];
            beat.keep[i]        = 1'b1;
         end
         idx       += n;
         beat.last  = (idx == tbl[r].len);
         s_beat_i   = beat;
         s_valid_i  = 1'b1;
         // Ready only changes on an edge and is settled here
         while (!s_ready_o) begin
            @(posedge axis_clk);
            #1;
         end
         @(posedge axis_clk);
         #1;
      end
   endtask

   initial begin
      axis_clk = 1'b0;
      forever #2 axis_clk = ~axis_clk;
   end

   // Output ready stalls at random while a stalled row's packet leaves the DUT
   initial begin
      int cur_row;
      forever begin
         @(posedge axis_clk);
         #1;
         rdy_state = lcg_next(rdy_state);
         cur_row   = (u_checker.pkt_done < N_TESTS) ? u_checker.pkt_done : N_TESTS - 1;
         m_ready_i = tbl[cur_row].stall ? rdy_state[20] : 1'b1;
      end
   end

   initial begin
      int limit;
      @(posedge axis_rst_n);
      limit = 10 * table_beats() + 100;
      repeat (limit) @(posedge axis_clk);
      $display("Timeout: not all packets left the DUT within %0d cycles", limit);
      $display("Regression failed");
      $finish;
   end

   initial begin
      axis_rst_n = 1'b0;
      s_beat_i   = '0;
      s_valid_i  = 1'b0;
      m_ready_i  = 1'b0;
      byte_state = SEED;
      rdy_state  = SEED;
      load_table();
      repeat (RST_CYCLES) @(posedge axis_clk);
      #1;
      axis_rst_n = 1'b1;
      for (int r = 0; r < N_TESTS; r++) begin
         send_packet(r);
      end
      s_valid_i = 1'b0;
      while (u_checker.pkt_done < N_TESTS) begin
         @(posedge axis_clk);
      end
      // A few idle cycles catch any extra output beat
      repeat (4) @(posedge axis_clk);
      $display("Tests run %0d, failed %0d, beat errors %0d, assertion failures %0d",
               u_checker.pkt_done, u_checker.pkt_failed, u_checker.err_cnt,
               UUT.u_props.fail_cnt);
      if (u_checker.err_cnt == 0 && UUT.u_props.fail_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: axis_pkt_trailer.f
common/axis_pkt_pkg.sv
verilog/axis_reg_slice.sv
trailer/pkt_accum.sv
trailer/trailer_insert.sv
verilog/axis_pkt_trailer_top.sv
verification/axis_pkt_checker.sv
verification/axis_pkt_trailer_props.sv
verification/axis_pkt_trailer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the packet trailer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module axis_pkt_trailer_tb \
   -f axis_pkt_trailer.f -o sim_axis_pkt_trailer \
   || { echo "Build failed"; exit 1; }

./obj_dir/sim_axis_pkt_trailer +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -qx "Regression passed" sim.log && echo "Simulation OK" \
   || { echo "Simulation reported errors"; exit 1; }
